/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/pipe_if.sv
  - src/reg_file.sv
  - src/fetch_unit.sv
  - src/decode_unit.sv
  - src/execute_unit.sv
  - src/memory_unit.sv
  - src/rv_core_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv_core.sv

/* list.f */
+incdir+testbench
src/rv_pkg.sv
src/pipe_if.sv
src/reg_file.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/memory_unit.sv
src/rv_core_top.sv
testbench/tb_rv_core.sv

/* src/decode_unit.sv */
/*
  Opcode decode, immediates, hazard and halt detection, ID/EX register.
  Opcodes outside the kept set decode with all control bits low.
  ecall reads a7 in place of rs1 and waits while a7 is still in EX or MEM.
*/
`timescale 1ns/1ps

module decode_unit (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::word_t    if_inst,
  output logic             stall,
  output logic             halt_seen,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::word_t    wb_data,
  input  rv_pkg::reg_idx_t dbg_addr,
  output rv_pkg::word_t    dbg_data,
  id_ex_if.producer        id_ex,
  ex_mem_if.consumer       ex_mem
);

  rv_pkg::opcode_e  opcode;
  rv_pkg::reg_idx_t rd, rs1, rs2, rs1_sel;
  logic [2:0]       funct3;
  logic             funct7;
  rv_pkg::word_t    rs1_data, rs2_data, i_imm, s_imm;
  rv_pkg::alu_op_e  alu_op;
  logic             reg_write, mem_read, mem_write, mem_to_reg, alu_src, is_ecall;
  logic             use_rs1, use_rs2, halt, load_use, ecall_wait;

  assign opcode = rv_pkg::opcode_e'(if_inst[rv_pkg::opcode_w-1:0]);
  assign rd     = if_inst[rv_pkg::rd_lsb +: rv_pkg::reg_addr_w];
  assign rs1    = if_inst[rv_pkg::rs1_lsb +: rv_pkg::reg_addr_w];
  assign rs2    = if_inst[rv_pkg::rs2_lsb +: rv_pkg::reg_addr_w];
  assign funct3 = if_inst[rv_pkg::funct3_lsb +: 3];
  assign funct7 = if_inst[rv_pkg::funct7_bit];
  assign i_imm  = {{20{if_inst[31]}}, if_inst[31:rv_pkg::rs2_lsb]};
  assign s_imm  = {{20{if_inst[31]}}, if_inst[31:rv_pkg::funct7_lsb],
                   if_inst[rv_pkg::rd_lsb +: 5]};

  always_comb begin
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    alu_src    = 1'b0;
    alu_op     = rv_pkg::alu_add;
    is_ecall   = 1'b0;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    case (opcode)
      rv_pkg::op_reg: begin
        reg_write = 1'b1;
        alu_op    = rv_pkg::alu_reg;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
      end
      rv_pkg::op_imm: begin
        reg_write = 1'b1;
        alu_src   = 1'b1;
        alu_op    = rv_pkg::alu_imm;
        use_rs1   = 1'b1;
      end
      rv_pkg::op_load: begin
        reg_write  = 1'b1;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        alu_src    = 1'b1;                             // base + i_imm
        use_rs1    = 1'b1;
      end
      rv_pkg::op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;                              // base + s_imm
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;                              // store data
      end
      rv_pkg::op_system: begin
        is_ecall = (funct3 == 3'b000) && (i_imm == '0); // ebreak etc. ignored
        use_rs1  = is_ecall;
      end
      default: ;                                       // bubble
    endcase
  end

  assign rs1_sel = is_ecall ? rv_pkg::ecall_reg : rs1; // ecall looks at a7
  assign halt    = is_ecall && (rs1_data == rv_pkg::halt_code);

  // load result not ready for the next instruction
  assign load_use   = id_ex.mem_read && (id_ex.rd != '0) &&
                      ((use_rs1 && id_ex.rd == rs1_sel) || (use_rs2 && id_ex.rd == rs2));
  // a7 still in flight, WB is covered by the register file bypass
  assign ecall_wait = is_ecall &&
                      ((id_ex.reg_write && id_ex.rd == rv_pkg::ecall_reg) ||
                       (ex_mem.reg_write && ex_mem.rd == rv_pkg::ecall_reg));
  assign stall      = load_use || ecall_wait;
  assign halt_seen  = halt && !stall;

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1_sel),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wb_en),
    .wr_addr  (wb_rd),
    .wr_data  (wb_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  // ID/EX control, bubble on stall
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      id_ex.reg_write  <= 1'b0;
      id_ex.mem_read   <= 1'b0;
      id_ex.mem_write  <= 1'b0;
      id_ex.mem_to_reg <= 1'b0;
      id_ex.halt       <= 1'b0;
    end else begin
      id_ex.reg_write  <= reg_write;
      id_ex.mem_read   <= mem_read;
      id_ex.mem_write  <= mem_write;
      id_ex.mem_to_reg <= mem_to_reg;
      id_ex.halt       <= halt;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    id_ex.alu_src  <= alu_src;
    id_ex.alu_op   <= alu_op;
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.imm      <= (opcode == rv_pkg::op_store) ? s_imm : i_imm;
    id_ex.rd       <= rd;
    id_ex.rs1      <= rs1_sel;
    id_ex.rs2      <= rs2;
    id_ex.funct3   <= funct3;
    id_ex.funct7   <= funct7;
  end

endmodule

/* src/execute_unit.sv */
/*
  Operand forwarding, ALU control, ALU and EX/MEM register.
  EX/MEM result beats WB data, x0 is never forwarded.
  A load in EX/MEM is never a forward source, decode stalls for that case.
*/
`timescale 1ns/1ps

module execute_unit (
  input  logic             clk,
  input  logic             reset,
  id_ex_if.consumer        id_ex,
  ex_mem_if.producer       ex_mem,
  input  logic             wb_en,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::word_t    wb_data
);

  localparam int shamt_w = $clog2(rv_pkg::xlen);

  rv_pkg::word_t   op_a, rs2_fwd, op_b, alu_out;
  rv_pkg::alu_fn_e alu_fn;

  // newest producer wins
  function automatic rv_pkg::word_t fwd(input rv_pkg::reg_idx_t idx,
                                        input rv_pkg::word_t id_val);
    rv_pkg::word_t val;
    val = id_val;
    if (idx != '0 && wb_en && wb_rd == idx) val = wb_data;
    if (idx != '0 && ex_mem.reg_write && ex_mem.rd == idx) val = ex_mem.alu_out;
    return val;
  endfunction

  always_comb begin
    op_a    = fwd(id_ex.rs1, id_ex.rs1_data);
    rs2_fwd = fwd(id_ex.rs2, id_ex.rs2_data);        // also store data
    op_b    = id_ex.alu_src ? id_ex.imm : rs2_fwd;
  end

  // funct7 bit only matters for sub and the right shifts
  always_comb begin
    alu_fn = rv_pkg::fn_add;
    if (id_ex.alu_op != rv_pkg::alu_add) begin
      case (id_ex.funct3)
        3'b000:  alu_fn = (id_ex.alu_op == rv_pkg::alu_reg && id_ex.funct7) ?
                          rv_pkg::fn_sub : rv_pkg::fn_add; // addi never subtracts
        3'b001:  alu_fn = rv_pkg::fn_sll;
        3'b010:  alu_fn = rv_pkg::fn_slt;
        3'b011:  alu_fn = rv_pkg::fn_sltu;
        3'b100:  alu_fn = rv_pkg::fn_xor;
        3'b101:  alu_fn = id_ex.funct7 ? rv_pkg::fn_sra : rv_pkg::fn_srl;
        3'b110:  alu_fn = rv_pkg::fn_or;
        default: alu_fn = rv_pkg::fn_and;
      endcase
    end
  end

  always_comb begin
    case (alu_fn)
      rv_pkg::fn_sub:  alu_out = op_a - op_b;
      rv_pkg::fn_sll:  alu_out = op_a << op_b[shamt_w-1:0];
      rv_pkg::fn_slt:  alu_out = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::fn_sltu: alu_out = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
      rv_pkg::fn_xor:  alu_out = op_a ^ op_b;
      rv_pkg::fn_srl:  alu_out = op_a >> op_b[shamt_w-1:0];
      rv_pkg::fn_sra:  alu_out = $signed(op_a) >>> op_b[shamt_w-1:0];
      rv_pkg::fn_or:   alu_out = op_a | op_b;
      rv_pkg::fn_and:  alu_out = op_a & op_b;
      default:         alu_out = op_a + op_b;          // add, addresses
    endcase
  end

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.reg_write  <= 1'b0;
      ex_mem.mem_read   <= 1'b0;
      ex_mem.mem_write  <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.halt       <= 1'b0;
    end else begin
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.mem_read   <= id_ex.mem_read;
      ex_mem.mem_write  <= id_ex.mem_write;
      ex_mem.mem_to_reg <= id_ex.mem_to_reg;
      ex_mem.halt       <= id_ex.halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    ex_mem.alu_out    <= alu_out;
    ex_mem.store_data <= rs2_fwd;
    ex_mem.rd         <= id_ex.rd;
  end

endmodule

/* src/fetch_unit.sv */
/*
  Run-state FSM, pc and word-addressed instruction memory.
  Program words are written only in st_load; the pc starts at 0 after run.
  Once a halt is seen the IF/ID register only receives zero words (bubbles).
*/
`timescale 1ns/1ps

module fetch_unit #(
  parameter int imem_words = 256
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          prog_valid,
  output logic          prog_ready,
  input  rv_pkg::word_t prog_addr,
  input  rv_pkg::word_t prog_data,
  input  logic          run,
  input  logic          stall,
  input  logic          halt_seen,
  output rv_pkg::word_t if_inst
);

  localparam int imem_aw = $clog2(imem_words);

  rv_pkg::run_state_e state;
  rv_pkg::word_t      pc;                 // byte address
  rv_pkg::word_t      imem [imem_words];

  assign prog_ready = (state == rv_pkg::st_load); // only handshake in the core

  // program port, word indexed
  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready) begin
      imem[prog_addr[imem_aw-1:0]] <= prog_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= rv_pkg::st_load;
      pc      <= '0;
      if_inst <= '0;
    end else begin
      case (state)
        rv_pkg::st_load: begin
          if (run) begin
            state <= rv_pkg::st_run;
            pc    <= '0;                             // first fetch next cycle
          end
        end
        rv_pkg::st_run: begin
          if (halt_seen) begin
            state   <= rv_pkg::st_drain;
            if_inst <= '0;                           // nothing younger than ecall
          end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_inst <= imem[pc[imem_aw+1:2]];
          end
        end
        rv_pkg::st_drain: if_inst <= '0;             // stays here until reset
        default: state <= rv_pkg::st_load;
      endcase
    end
  end

endmodule

/* src/memory_unit.sv */
/*
  Word-addressed data memory, MEM/WB register and writeback select.
  The byte address is cut to a word index, the low two bits are ignored.
  is_halted is sticky until reset.
*/
`timescale 1ns/1ps

module memory_unit #(
  parameter int dmem_words = 256
) (
  input  logic             clk,
  input  logic             reset,
  ex_mem_if.consumer       ex_mem,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output logic             is_halted
);

  localparam int dmem_aw = $clog2(dmem_words);

  rv_pkg::word_t      dmem [dmem_words];
  logic [dmem_aw-1:0] dmem_idx;
  rv_pkg::word_t      load_q;      // lw data
  rv_pkg::word_t      alu_q;
  logic               mem_to_reg_q;

  assign dmem_idx = ex_mem.alu_out[dmem_aw+1:2]; // sw / lw word index

  always_ff @(posedge clk) begin
    if (ex_mem.mem_write) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    if (ex_mem.mem_read) begin
      load_q <= dmem[dmem_idx];                  // read latched here
    end
    alu_q <= ex_mem.alu_out;
    wb_rd <= ex_mem.rd;
  end

  // MEM/WB control
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en        <= 1'b0;
      mem_to_reg_q <= 1'b0;
      is_halted    <= 1'b0;
    end else begin
      wb_en        <= ex_mem.reg_write;
      mem_to_reg_q <= ex_mem.mem_to_reg;
      if (ex_mem.halt) begin
        is_halted <= 1'b1;                       // ecall now in WB
      end
    end
  end

  assign wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

/* src/pipe_if.sv */
/*
  Stage bundles between decode, execute and memory.
  Each bundle is written by exactly one stage register, the producer.
*/
`timescale 1ns/1ps

interface id_ex_if;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;
  logic              mem_to_reg;
  logic              alu_src;   // 1 selects imm for operand b
  rv_pkg::alu_op_e   alu_op;
  logic              halt;      // halting ecall
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     imm;
  rv_pkg::reg_idx_t  rd;
  rv_pkg::reg_idx_t  rs1;
  rv_pkg::reg_idx_t  rs2;
  logic [2:0]        funct3;
  logic              funct7;    // inst bit 30 only

  modport producer (output reg_write, mem_read, mem_write, mem_to_reg, alu_src, alu_op, halt,
                    rs1_data, rs2_data, imm, rd, rs1, rs2, funct3, funct7);
  modport consumer (input reg_write, mem_read, mem_write, mem_to_reg, alu_src, alu_op, halt,
                    rs1_data, rs2_data, imm, rd, rs1, rs2, funct3, funct7);
endinterface

interface ex_mem_if;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;
  logic              mem_to_reg;
  logic              halt;
  rv_pkg::word_t     alu_out;    // result or byte address
  rv_pkg::word_t     store_data; // already forwarded
  rv_pkg::reg_idx_t  rd;

  modport producer (output reg_write, mem_read, mem_write, mem_to_reg, halt,
                    alu_out, store_data, rd);
  modport consumer (input reg_write, mem_read, mem_write, mem_to_reg, halt,
                    alu_out, store_data, rd);
endinterface

/* src/reg_file.sv */
/*
  32 x 32 register file, two read ports plus a debug read port.
  x0 always reads zero. Reads see a write in the same cycle, the debug port does not.
*/
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             wr_en,
  input  rv_pkg::reg_idx_t wr_addr,
  input  rv_pkg::word_t    wr_data,
  input  rv_pkg::reg_idx_t dbg_addr,
  output rv_pkg::word_t    dbg_data
);

  rv_pkg::word_t regs [2**rv_pkg::reg_addr_w];
  logic          wr_live;

  assign wr_live  = wr_en && (wr_addr != '0); // x0 writes dropped

  assign rs1_data = (wr_live && wr_addr == rs1) ? wr_data : regs[rs1]; // WB bypass
  assign rs2_data = (wr_live && wr_addr == rs2) ? wr_data : regs[rs2];
  assign dbg_data = regs[dbg_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* src/rv_core_top.sv */
/*
  Five-stage in-order RV32I subset core, no branches or jumps.
  Load the program word by word while prog_ready is high, then pulse run.
  is_halted stays high after the ecall with a7 == 10 retires, until reset.
  imem_words and dmem_words must be powers of two.
*/
`timescale 1ns/1ps

module rv_core_top #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             prog_valid,
  output logic             prog_ready,
  input  rv_pkg::word_t    prog_addr,  // word index
  input  rv_pkg::word_t    prog_data,
  input  logic             run,
  output logic             is_halted,
  input  rv_pkg::reg_idx_t dbg_addr,
  output rv_pkg::word_t    dbg_data
);

  rv_pkg::word_t    if_inst;   // IF/ID instruction
  logic             stall;     // load-use or ecall wait
  logic             halt_seen; // halting ecall leaving decode
  logic             wb_en;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;

  id_ex_if  u_id_ex ();
  ex_mem_if u_ex_mem ();

  fetch_unit #(.imem_words(imem_words)) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .prog_valid (prog_valid),
    .prog_ready (prog_ready),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .run        (run),
    .stall      (stall),
    .halt_seen  (halt_seen),
    .if_inst    (if_inst)
  );

  decode_unit u_decode (
    .clk       (clk),
    .reset     (reset),
    .if_inst   (if_inst),
    .stall     (stall),
    .halt_seen (halt_seen),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .id_ex     (u_id_ex.producer),
    .ex_mem    (u_ex_mem.consumer)
  );

  execute_unit u_execute (
    .clk     (clk),
    .reset   (reset),
    .id_ex   (u_id_ex.consumer),
    .ex_mem  (u_ex_mem.producer),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  memory_unit #(.dmem_words(dmem_words)) u_memory (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (u_ex_mem.consumer),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .is_halted (is_halted)
  );

endmodule

/* src/rv_pkg.sv */
/*
  Shared widths, types and encodings for the five-stage RV32I core.
  Only the kept major opcodes are listed. Any other opcode is treated as a bubble.
  Field positions follow the base RV32I instruction formats.
*/
package rv_pkg;

  localparam int xlen       = 32; // one data word
  localparam int reg_addr_w = 5;  // 32 architectural registers
  localparam int opcode_w   = 7;

  // instruction field positions
  localparam int rd_lsb      = 7;
  localparam int funct3_lsb  = 12;
  localparam int rs1_lsb     = 15;
  localparam int rs2_lsb     = 20;
  localparam int funct7_lsb  = 25; // upper store immediate starts here
  localparam int funct7_bit  = 30; // sub / sra select

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  typedef enum logic [opcode_w-1:0] {
    op_reg    = 7'b0110011, // add, sub, sll ...
    op_imm    = 7'b0010011, // addi, slli ...
    op_load   = 7'b0000011, // lw only
    op_store  = 7'b0100011, // sw only
    op_system = 7'b1110011  // ecall
  } opcode_e;

  // decode class handed to ALU control
  typedef enum logic [1:0] {
    alu_add, // address calc for lw / sw
    alu_reg,
    alu_imm
  } alu_op_e;

  typedef enum logic [3:0] {
    fn_add,
    fn_sub,
    fn_sll,
    fn_slt,
    fn_sltu,
    fn_xor,
    fn_srl,
    fn_sra,
    fn_or,
    fn_and
  } alu_fn_e;

  typedef enum logic [1:0] {
    st_load,  // program port open
    st_run,   // fetching
    st_drain  // halt seen, bubbles only
  } run_state_e;

  localparam word_t    halt_code = 32'd10; // a7 value meaning exit
  localparam reg_idx_t ecall_reg = 5'd17;  // a7

endpackage

/* testbench/tb_rv_isa.svh */
/*
  RV32I encoders and a sequential reference model, included inside the testbench module.
  The model runs the words in prog from index 0 and stops at an ecall with x17 == 10.
  Data memory is 256 words indexed by byte address bits 9:2, as in the default core.
*/
`ifndef tb_rv_isa_svh
`define tb_rv_isa_svh

localparam logic [6:0]  opc_reg    = 7'b0110011;
localparam logic [6:0]  opc_imm    = 7'b0010011;
localparam logic [6:0]  opc_load   = 7'b0000011;
localparam logic [6:0]  opc_store  = 7'b0100011;
localparam logic [31:0] ecall_word = 32'h0000_0073;

logic [31:0] prog [$];        // program under test
logic [31:0] model_regs [32];
logic [31:0] model_mem [256]; // persists across programs like the DUT memory
int          model_halt_at;   // word index of halting ecall, -1 if none

// alt selects sub / sra
function automatic logic [31:0] rtype(input logic [2:0] f3, input logic alt,
                                      input logic [4:0] rd, rs1, rs2);
  return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, opc_reg};
endfunction

function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                      input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

// sw rs2, imm(rs1)
function automatic logic [31:0] stype(input logic [4:0] rs2, rs1, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'd0, $signed(a) < $signed(b)};
    3'b011:  return {31'd0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic void model_run();
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] addr;
  logic [4:0]  rd;
  logic [2:0]  f3;
  foreach (model_regs[i]) model_regs[i] = '0;
  model_halt_at = -1;
  for (int pc = 0; pc < prog.size() && model_halt_at < 0; pc++) begin
    inst  = prog[pc];
    rd    = inst[11:7];
    f3    = inst[14:12];
    a     = model_regs[inst[19:15]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    case (inst[6:0])
      opc_reg: model_regs[rd] = alu_ref(f3, inst[30], a, model_regs[inst[24:20]]);
      opc_imm: model_regs[rd] = alu_ref(f3, f3 == 3'b101 && inst[30], a, imm_i);
      opc_load: begin
        addr           = a + imm_i;
        model_regs[rd] = model_mem[addr[9:2]];
      end
      opc_store: begin
        addr                 = a + imm_s;
        model_mem[addr[9:2]] = model_regs[inst[24:20]];
      end
      default: begin
        if (inst == ecall_word && model_regs[17] == 32'd10) model_halt_at = pc;
      end
    endcase
    model_regs[0] = '0; // x0 stays zero
  end
endfunction

`endif

/* testbench/tb_rv_core.sv */
/*
  Loads programs into rv_core_top over the prog port, runs each one to the halting ecall
  and compares all 32 registers with the reference model through the debug port.
  Data memory is never cleared, so every program stores a word before it loads it.
*/
`timescale 1ns/1ps

module tb_rv_core;

  localparam int imem_words  = 256;
  localparam int dmem_words  = 256;
  localparam int halt_limit  = 1000; // cycles from run to is_halted
  localparam int ready_limit = 20;

  logic        clk;
  logic        reset;
  logic        prog_valid;
  logic        prog_ready;
  logic [31:0] prog_addr;
  logic [31:0] prog_data;
  logic        run;
  logic        is_halted;
  logic [4:0]  dbg_addr;
  logic [31:0] dbg_data;

  `include "tb_rv_isa.svh"

  rv_core_top #(
    .imem_words (imem_words),
    .dmem_words (dmem_words)
  ) u_rv_core_top (
    .clk        (clk),
    .reset      (reset),
    .prog_valid (prog_valid),
    .prog_ready (prog_ready),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .run        (run),
    .is_halted  (is_halted),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reset_core();
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // offer one word and hold it until the handshake completes
  task automatic load_word(input int addr, input logic [31:0] data);
    int cycles;
    cycles     = 0;
    prog_valid = 1'b1;
    prog_addr  = addr;
    prog_data  = data;
    while (prog_ready !== 1'b1) begin
      if (cycles == ready_limit) stop_run("timed out waiting for prog_ready while loading");
      @(posedge clk);
      #2;
      cycles++;
    end
    @(posedge clk); // word written here
    #2;
  endtask

  task automatic compare_regs(input string name);
    for (int i = 0; i < 32; i++) begin
      dbg_addr = 5'(i);
      #1;
      assert (dbg_data === model_regs[i])
        else stop_run($sformatf("error at %0t ns: %s x%0d = %h, expected %h",
                                $time, name, i, dbg_data, model_regs[i]));
      @(posedge clk);
      #2;
    end
  endtask

  task automatic run_program(input string name);
    int cycles;
    model_run();
    if (model_halt_at < 0) stop_run($sformatf("%s program never halts in the model", name));
    reset_core();
    assert (prog_ready === 1'b1 && is_halted === 1'b0)
      else stop_run($sformatf("error at %0t ns: %s after reset ready %b halted %b",
                              $time, name, prog_ready, is_halted));
    for (int i = 0; i < prog.size(); i++) load_word(i, prog[i]);
    for (int i = 0; i < 2; i++) load_word(prog.size() + i, 32'h0); // bubble padding
    prog_valid = 1'b0;
    run        = 1'b1;
    @(posedge clk);
    #2;
    run = 1'b0;
    assert (prog_ready === 1'b0)
      else stop_run($sformatf("error at %0t ns: %s prog_ready high after run", $time, name));
    // try to erase the halting ecall while the port is closed
    prog_valid = 1'b1;
    prog_addr  = model_halt_at;
    prog_data  = 32'h0;
    cycles     = 0;
    while (is_halted !== 1'b1) begin
      if (cycles == halt_limit) stop_run($sformatf("%s program did not halt in time", name));
      @(posedge clk);
      #2;
      cycles++;
    end
    prog_valid = 1'b0;
    repeat (5) @(posedge clk); // younger instructions would land here
    #2;
    assert (is_halted === 1'b1 && prog_ready === 1'b0)
      else stop_run($sformatf("error at %0t ns: %s halted %b ready %b after halt",
                              $time, name, is_halted, prog_ready));
    compare_regs(name);
    prog.delete();
  endtask

  // back-to-back dependencies through every ALU function
  task automatic chain_program();
    prog.push_back(itype(opc_imm, 3'b000, 5'd1, 5'd0, 12'd5));       // addi x1, x0, 5
    prog.push_back(itype(opc_imm, 3'b000, 5'd2, 5'd1, 12'd7));       // from EX/MEM
    prog.push_back(rtype(3'b000, 1'b0, 5'd3, 5'd1, 5'd2));           // add from WB and EX/MEM
    prog.push_back(rtype(3'b000, 1'b1, 5'd4, 5'd3, 5'd1));           // sub
    prog.push_back(rtype(3'b001, 1'b0, 5'd5, 5'd4, 5'd1));           // sll
    prog.push_back(itype(opc_imm, 3'b000, 5'd7, 5'd0, 12'hffd));     // addi x7, x0, -3
    prog.push_back(rtype(3'b010, 1'b0, 5'd6, 5'd7, 5'd1));           // slt
    prog.push_back(rtype(3'b011, 1'b0, 5'd8, 5'd7, 5'd1));           // sltu
    prog.push_back(rtype(3'b100, 1'b0, 5'd9, 5'd7, 5'd3));           // xor
    prog.push_back(rtype(3'b101, 1'b0, 5'd10, 5'd7, 5'd1));          // srl
    prog.push_back(rtype(3'b101, 1'b1, 5'd11, 5'd7, 5'd1));          // sra
    prog.push_back(rtype(3'b110, 1'b0, 5'd12, 5'd9, 5'd2));          // or
    prog.push_back(rtype(3'b111, 1'b0, 5'd13, 5'd12, 5'd7));         // and
    prog.push_back(itype(opc_imm, 3'b010, 5'd14, 5'd13, 12'h800));   // slti
    prog.push_back(itype(opc_imm, 3'b011, 5'd15, 5'd7, 12'd4));      // sltiu
    prog.push_back(itype(opc_imm, 3'b100, 5'd16, 5'd15, 12'h5a5));   // xori
    prog.push_back(itype(opc_imm, 3'b110, 5'd18, 5'd16, 12'h0f0));   // ori
    prog.push_back(itype(opc_imm, 3'b111, 5'd19, 5'd18, 12'h7c3));   // andi
    prog.push_back(itype(opc_imm, 3'b001, 5'd20, 5'd19, 12'd9));     // slli
    prog.push_back(itype(opc_imm, 3'b101, 5'd21, 5'd7, 12'd4));      // srli
    prog.push_back(itype(opc_imm, 3'b101, 5'd22, 5'd7, 12'h404));    // srai
    prog.push_back(itype(opc_imm, 3'b000, 5'd17, 5'd0, 12'd10));     // a7 = 10
    prog.push_back(ecall_word);
  endtask

  task automatic memory_program();
    prog.push_back(itype(opc_imm, 3'b000, 5'd1, 5'd0, 12'd64));      // base
    prog.push_back(itype(opc_imm, 3'b000, 5'd2, 5'd0, 12'd123));
    prog.push_back(stype(5'd2, 5'd1, 12'd0));                        // sw x2, 0(x1)
    prog.push_back(rtype(3'b000, 1'b0, 5'd3, 5'd2, 5'd2));
    prog.push_back(stype(5'd3, 5'd1, 12'd4));                        // fresh store data
    prog.push_back(itype(opc_load, 3'b010, 5'd4, 5'd1, 12'd0));      // lw x4, 0(x1)
    prog.push_back(rtype(3'b000, 1'b0, 5'd5, 5'd4, 5'd4));           // load-use bubble
    prog.push_back(itype(opc_load, 3'b010, 5'd6, 5'd1, 12'd4));
    prog.push_back(stype(5'd6, 5'd1, 12'd8));                        // store just-loaded
    prog.push_back(itype(opc_load, 3'b010, 5'd7, 5'd1, 12'd8));
    prog.push_back(itype(opc_imm, 3'b000, 5'd8, 5'd7, 12'hfff));
    prog.push_back(rtype(3'b000, 1'b1, 5'd9, 5'd8, 5'd4));
    prog.push_back(itype(opc_imm, 3'b000, 5'd17, 5'd0, 12'd10));
    prog.push_back(ecall_word);
  endtask

  task automatic ecall_program();
    prog.push_back(itype(opc_imm, 3'b000, 5'd2, 5'd0, 12'd3));
    prog.push_back(stype(5'd2, 5'd0, 12'd128));
    prog.push_back(itype(opc_load, 3'b010, 5'd17, 5'd0, 12'd128));   // a7 = 3 from memory
    prog.push_back(ecall_word);                                      // no halt
    prog.push_back(itype(opc_imm, 3'b000, 5'd5, 5'd0, 12'd1));
    prog.push_back(itype(opc_imm, 3'b000, 5'd0, 5'd0, 12'd9));       // x0 writes
    prog.push_back(rtype(3'b000, 1'b0, 5'd0, 5'd5, 5'd5));
    prog.push_back(rtype(3'b000, 1'b0, 5'd6, 5'd0, 5'd5));           // x0 not forwarded
    prog.push_back(itype(opc_imm, 3'b000, 5'd17, 5'd0, 12'd10));
    prog.push_back(ecall_word);                                      // waits on a7 then halts
    prog.push_back(itype(opc_imm, 3'b000, 5'd5, 5'd0, 12'd77));      // younger than halt
    prog.push_back(itype(opc_imm, 3'b000, 5'd17, 5'd0, 12'd1));
    prog.push_back(stype(5'd5, 5'd0, 12'd128));
  endtask

  // registers x0..x5 and data words 0..3 only
  task automatic random_program();
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(itype(opc_imm, 3'b000, 5'(r), 5'd0, 12'($urandom)));
    end
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(stype(5'(r), 5'd0, 12'((r - 1) * 4)));
    end
    for (int n = 0; n < 40; n++) begin
      kind = $urandom % 10;
      rd   = 5'($urandom % 6);
      rs1  = 5'($urandom % 6);
      rs2  = 5'($urandom % 6);
      f3   = 3'($urandom);
      imm  = 12'($urandom);
      if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, imm[10], 5'd0, imm[4:0]}; // shamt form
      case (kind)
        0, 1, 2, 3: prog.push_back(rtype(f3, (f3 == 3'b000 || f3 == 3'b101) && imm[10],
                                         rd, rs1, rs2));
        4, 5, 6: prog.push_back(itype(opc_imm, f3, rd, rs1, imm));
        7: prog.push_back(itype(opc_load, 3'b010, rd, 5'd0, 12'(4 * ($urandom % 4))));
        8: prog.push_back(stype(rs2, 5'd0, 12'(4 * ($urandom % 4))));
        default: prog.push_back(ecall_word); // a7 is 0 here
      endcase
    end
    prog.push_back(itype(opc_imm, 3'b000, 5'd17, 5'd0, 12'd10));
    prog.push_back(ecall_word);
  endtask

  initial begin
    void'($urandom(32'h0971e516)); // one seed for the whole run
    reset      = 1'b1;
    prog_valid = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    run        = 1'b0;
    dbg_addr   = '0;
    chain_program();
    run_program("alu chain");
    memory_program();
    run_program("load store");
    ecall_program();
    run_program("ecall");
    random_program();
    run_program("random");
    $display("Everything OK");
    $finish;
  end

endmodule
